// ==== all.f ====
common/apu_pkg.sv
logic/apu_reg_if.sv
wave/wave_ram.sv
wave/wave_timer.sv
logic/wave_out.sv
logic/wave_channel.sv
test/tb_clock.sv
test/wave_channel_tb.sv

// ==== test/wave_channel_tb.sv ====
module wave_channel_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          TIMER_DIV  = 2;
	localparam logic [10:0] FREQ       = 11'd2044;
	localparam int          PERIOD     = TIMER_DIV * (2048 - int'(FREQ)); // cycles per position
	localparam int          WAIT_LIMIT = 1000;

	typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_TRIGGER, OP_PLAY, OP_LENGTH} op_e;

	typedef struct packed {
		op_e        op;
		logic [7:0] addr;
		logic [7:0] data;     // write value, position or tick count
		logic [7:0] expected;
	} entry_t;

	logic              amuk_4mhz;
	logic              arst_n;
	apu_pkg::cpu_bus_t bus;
	logic              len_tick;
	logic [7:0]        rdata;
	logic [3:0]        sample;
	logic              ch3_active;

	entry_t      table_q[$];
	string       name_q[$];
	logic [7:0]  model_ram [16];
	logic [31:0] rng_state;
	int          since_trig; // cycles since the trigger edge

	tb_clock u_clock (
		.clk    (amuk_4mhz),
		.arst_n (arst_n)
	);

	wave_channel #(
		.TIMER_DIV (TIMER_DIV)
	) UUT (
		.amuk_4mhz  (amuk_4mhz),
		.arst_n     (arst_n),
		.bus        (bus),
		.len_tick   (len_tick),
		.rdata      (rdata),
		.sample     (sample),
		.ch3_active (ch3_active)
	);

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// high nibble on even positions and position wraps at 32
	function automatic logic [3:0] model_nibble(input int k);
		logic [4:0] pos;
		logic [7:0] byte_val;
		pos      = 5'(k % 32);
		byte_val = model_ram[pos[4:1]];
		return pos[0] ? byte_val[3:0] : byte_val[7:4];
	endfunction

	function automatic logic [3:0] apply_volume(input logic [3:0] nib,
			input apu_pkg::wave_vol_e vol);
		case (vol)
			apu_pkg::VOL_FULL:    return nib;
			apu_pkg::VOL_HALF:    return nib >> 1;
			apu_pkg::VOL_QUARTER: return nib >> 2;
			default:              return 4'h0;
		endcase
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic value_error(input string name, input logic [7:0] exp, input logic [7:0] act);
		report_failure($sformatf("ERROR %s: expected %02h, actual %02h", name, exp, act));
	endtask

	task automatic add_entry(input string name, input op_e op, input logic [7:0] addr,
			input logic [7:0] data, input logic [7:0] expected);
		entry_t e;
		e.op       = op;
		e.addr     = addr;
		e.data     = data;
		e.expected = expected;
		table_q.push_back(e);
		name_q.push_back(name);
	endtask

	task automatic add_playback(input string name, input apu_pkg::wave_vol_e vol);
		add_entry({name, " vol"}, OP_WRITE, apu_pkg::NR32, {1'b0, vol, 5'h00}, 8'h00);
		add_entry({name, " dac"}, OP_WRITE, apu_pkg::NR30, 8'h80, 8'h00);
		add_entry({name, " freq"}, OP_WRITE, apu_pkg::NR33, FREQ[7:0], 8'h00);
		add_entry({name, " trig"}, OP_TRIGGER, apu_pkg::NR34, {5'b10000, FREQ[10:8]}, 8'h00);
		for (int k = 0; k < 34; k++) begin // runs past the 31 -> 0 wrap
			add_entry($sformatf("%s pos %0d", name, k), OP_PLAY, 8'h00, 8'(k),
				{4'h0, apply_volume(model_nibble(k), vol)});
		end
	endtask

	task automatic build_table();
		add_entry("nr30 on", OP_WRITE, apu_pkg::NR30, 8'h80, 8'h00);
		add_entry("nr30 on", OP_READ, apu_pkg::NR30, 8'h00, 8'hFF);
		add_entry("nr30 off", OP_WRITE, apu_pkg::NR30, 8'h00, 8'h00);
		add_entry("nr30 off", OP_READ, apu_pkg::NR30, 8'h00, 8'h7F);
		add_entry("nr32 half", OP_WRITE, apu_pkg::NR32, 8'h40, 8'h00);
		add_entry("nr32 half", OP_READ, apu_pkg::NR32, 8'h00, 8'hDF);
		add_entry("nr32 quarter", OP_WRITE, apu_pkg::NR32, 8'h60, 8'h00);
		add_entry("nr32 quarter", OP_READ, apu_pkg::NR32, 8'h00, 8'hFF);
		add_entry("nr32 mute", OP_WRITE, apu_pkg::NR32, 8'h00, 8'h00);
		add_entry("nr32 mute", OP_READ, apu_pkg::NR32, 8'h00, 8'h9F);
		add_entry("nr34 len on", OP_WRITE, apu_pkg::NR34, 8'h40, 8'h00);
		add_entry("nr34 len on", OP_READ, apu_pkg::NR34, 8'h00, 8'hFF);
		add_entry("nr34 len off", OP_WRITE, apu_pkg::NR34, 8'h00, 8'h00);
		add_entry("nr34 len off", OP_READ, apu_pkg::NR34, 8'h00, 8'hBF);
		add_entry("nr31", OP_WRITE, apu_pkg::NR31, 8'h12, 8'h00);
		add_entry("nr31", OP_READ, apu_pkg::NR31, 8'h00, 8'hFF);
		add_entry("nr33", OP_READ, apu_pkg::NR33, 8'h00, 8'hFF);
		add_entry("unmapped 10", OP_READ, 8'h10, 8'h00, 8'hFF);
		add_entry("unmapped 27", OP_READ, 8'h27, 8'h00, 8'hFF);
		add_entry("unmapped 40", OP_READ, 8'h40, 8'h00, 8'hFF);
		for (int i = 0; i < 16; i++) begin
			add_entry($sformatf("ram wr %0d", i), OP_WRITE, 8'(8'h30 + i), model_ram[i], 8'h00);
		end
		for (int i = 0; i < 16; i++) begin
			add_entry($sformatf("ram rd %0d", i), OP_READ, 8'(8'h30 + i), 8'h00, model_ram[i]);
		end
		add_playback("full", apu_pkg::VOL_FULL);
		add_playback("half", apu_pkg::VOL_HALF);
		add_playback("quarter", apu_pkg::VOL_QUARTER);
		add_playback("mute", apu_pkg::VOL_MUTE);
		// full volume so a stopped channel has to force the sample to zero
		add_entry("len vol", OP_WRITE, apu_pkg::NR32, 8'h20, 8'h00);
		// 250 loaded, so the sixth tick wraps the counter
		add_entry("len load", OP_WRITE, apu_pkg::NR31, 8'hFA, 8'h00);
		add_entry("len dac", OP_WRITE, apu_pkg::NR30, 8'h80, 8'h00);
		add_entry("len trig", OP_TRIGGER, apu_pkg::NR34, 8'hC7, 8'h00);
		add_entry("len 5 ticks", OP_LENGTH, 8'h00, 8'd5, 8'h01);
		add_entry("len 6th tick", OP_LENGTH, 8'h00, 8'd1, 8'h00);
		add_entry("dac trig", OP_TRIGGER, apu_pkg::NR34, 8'h87, 8'h00);
		add_entry("dac playing", OP_LENGTH, 8'h00, 8'd0, 8'h01);
		add_entry("dac clear", OP_WRITE, apu_pkg::NR30, 8'h00, 8'h00);
		add_entry("dac stopped", OP_LENGTH, 8'h00, 8'd0, 8'h00);
		add_entry("lock dac", OP_WRITE, apu_pkg::NR30, 8'h80, 8'h00);
		add_entry("lock trig", OP_TRIGGER, apu_pkg::NR34, 8'h87, 8'h00);
		add_entry("lock rd 30", OP_READ, 8'h30, 8'h00, 8'hFF);
		add_entry("lock rd 3f", OP_READ, 8'h3F, 8'h00, 8'hFF);
		add_entry("lock wr 35", OP_WRITE, 8'h35, ~model_ram[5], 8'h00);
		add_entry("lock stop", OP_WRITE, apu_pkg::NR30, 8'h00, 8'h00);
		add_entry("lock stopped", OP_LENGTH, 8'h00, 8'd0, 8'h00);
		add_entry("lock rd 35", OP_READ, 8'h35, 8'h00, model_ram[5]);
	endtask

	task automatic next_cycle();
		@(negedge amuk_4mhz);
		since_trig++;
	endtask

	task automatic cpu_write(input logic [7:0] addr, input logic [7:0] data);
		bus.rd    = 1'b0;
		bus.wr    = 1'b1;
		bus.addr  = addr;
		bus.wdata = data;
		next_cycle();
		bus = '0;
	endtask

	task automatic cpu_read(input logic [7:0] addr, output logic [7:0] data);
		bus.rd    = 1'b1;
		bus.wr    = 1'b0;
		bus.addr  = addr;
		bus.wdata = 8'h00;
		next_cycle();
		bus  = '0;
		data = rdata; // registered one cycle after the strobe
	endtask

	task automatic run_entry(input int idx);
		entry_t     e;
		string      name;
		logic [7:0] got;
		int         target;
		int         guard;
		e    = table_q[idx];
		name = name_q[idx];
		case (e.op)
			OP_WRITE: cpu_write(e.addr, e.data);
			OP_READ: begin
				cpu_read(e.addr, got);
				assert (got === e.expected) else value_error(name, e.expected, got);
			end
			OP_TRIGGER: begin
				cpu_write(e.addr, e.data);
				since_trig = 0;
			end
			OP_PLAY: begin
				target = 2 + int'(e.data) * PERIOD; // two register stages after position
				if (since_trig > target) begin
					report_failure($sformatf("%s comes after its sample time", name));
				end
				guard = 0;
				while (since_trig < target) begin
					if (guard == WAIT_LIMIT) begin
						report_failure($sformatf("timeout waiting for the sample time of %s", name));
					end
					guard++;
					next_cycle();
				end
				got = {4'h0, sample};
				assert (got === e.expected) else value_error(name, e.expected, got);
			end
			OP_LENGTH: begin
				for (int t = 0; t < int'(e.data); t++) begin
					len_tick = 1'b1;
					next_cycle();
					len_tick = 1'b0;
					next_cycle();
				end
				assert (ch3_active === e.expected[0])
					else value_error(name, e.expected, {7'h00, ch3_active});
				if (!e.expected[0]) begin
					next_cycle();
					assert (sample === 4'h0)
						else value_error({name, " sample"}, 8'h00, {4'h0, sample});
				end
			end
			default: report_failure($sformatf("unknown operation in entry %0d", idx));
		endcase
	endtask

	initial begin
		int guard;
		bus        = '0;
		len_tick   = 1'b0;
		since_trig = 0;
		rng_state  = 32'h6df6;
		for (int i = 0; i < 16; i++) begin
			rng_state    = next_random(rng_state);
			model_ram[i] = rng_state[7:0];
		end
		build_table();
		guard = 0;
		while (arst_n !== 1'b1) begin
			if (guard == WAIT_LIMIT) begin
				report_failure("timeout waiting for reset to be released");
			end
			guard++;
			@(negedge amuk_4mhz);
		end
		assert (sample === 4'h0) else value_error("reset sample", 8'h00, {4'h0, sample});
		assert (ch3_active === 1'b0) else value_error("reset active", 8'h00, {7'h00, ch3_active});
		assert (rdata === 8'h00) else value_error("reset rdata", 8'h00, rdata);
		for (int i = 0; i < table_q.size(); i++) begin
			run_entry(i);
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== test/tb_clock.sv ====
module tb_clock (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (10) @(negedge clk);
		arst_n = 1'b1; // released away from the rising edge
	end

endmodule

// ==== logic/wave_channel.sv ====
module wave_channel #(
	parameter int TIMER_DIV = 1
) (
	input  logic              amuk_4mhz,
	input  logic              arst_n,
	input  apu_pkg::cpu_bus_t bus,
	input  logic              len_tick,
	output logic [7:0]        rdata,
	output logic [3:0]        sample,
	output logic              ch3_active
);
	apu_pkg::ch3_cfg_t         cfg;
	logic                      trigger;
	logic                      len_reload;
	logic                      ram_rd;
	logic                      ram_wr;
	logic [3:0]                ram_addr;
	logic [7:0]                wdata;
	logic [7:0]                ram_rdata;
	logic [apu_pkg::POS_W-1:0] position;
	logic [3:0]                raw_sample;

	apu_reg_if u_reg_if (
		.amuk_4mhz  (amuk_4mhz),
		.arst_n     (arst_n),
		.bus        (bus),
		.ch3_active (ch3_active),
		.ram_rdata  (ram_rdata),
		.rdata      (rdata),
		.cfg        (cfg),
		.trigger    (trigger),
		.len_reload (len_reload),
		.ram_rd     (ram_rd),
		.ram_wr     (ram_wr),
		.ram_addr   (ram_addr),
		.wdata      (wdata)
	);

	wave_ram u_wave_ram (
		.amuk_4mhz  (amuk_4mhz),
		.arst_n     (arst_n),
		.ram_rd     (ram_rd),
		.ram_wr     (ram_wr),
		.ram_addr   (ram_addr),
		.wdata      (wdata),
		.position   (position),
		.ram_rdata  (ram_rdata),
		.raw_sample (raw_sample)
	);

	wave_timer #(
		.TIMER_DIV (TIMER_DIV)
	) u_wave_timer (
		.amuk_4mhz  (amuk_4mhz),
		.arst_n     (arst_n),
		.cfg        (cfg),
		.trigger    (trigger),
		.len_reload (len_reload),
		.len_tick   (len_tick),
		.position   (position),
		.ch3_active (ch3_active)
	);

	wave_out u_wave_out (
		.amuk_4mhz  (amuk_4mhz),
		.arst_n     (arst_n),
		.raw_sample (raw_sample),
		.vol        (cfg.vol),
		.ch3_active (ch3_active),
		.sample     (sample)
	);

endmodule

// ==== logic/wave_out.sv ====
module wave_out (
	input  logic               amuk_4mhz,
	input  logic               arst_n,
	input  logic [3:0]         raw_sample,
	input  apu_pkg::wave_vol_e vol,
	input  logic               ch3_active,
	output logic [3:0]         sample
);
	logic [3:0] scaled;

	always_comb begin
		case (vol)
			apu_pkg::VOL_FULL:    scaled = raw_sample;
			apu_pkg::VOL_HALF:    scaled = raw_sample >> 1;
			apu_pkg::VOL_QUARTER: scaled = raw_sample >> 2;
			default:              scaled = '0; // mute
		endcase
	end

	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			sample <= '0;
		end else begin
			sample <= ch3_active ? scaled : 4'h0; // silent when off
		end
	end

endmodule

// ==== wave/wave_timer.sv ====
module wave_timer #(
	parameter int TIMER_DIV = 1
) (
	input  logic                      amuk_4mhz,
	input  logic                      arst_n,
	input  apu_pkg::ch3_cfg_t         cfg,
	input  logic                      trigger,
	input  logic                      len_reload,
	input  logic                      len_tick,
	output logic [apu_pkg::POS_W-1:0] position,
	output logic                      ch3_active
);
	localparam int PRE_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TIMER_DIV - 1);
	localparam logic [apu_pkg::FREQ_W-1:0] FREQ_MAX = '1;

	apu_pkg::ch_state_e          state;
	logic [PRE_W-1:0]            pre_cnt;
	logic [apu_pkg::FREQ_W-1:0]  freq_cnt;
	logic [7:0]                  len_cnt;
	logic                        step;
	logic                        len_step;
	logic                        len_done;

	assign step     = state == apu_pkg::CH_PLAY && pre_cnt == PRE_LAST; // prescaler tick
	assign len_step = len_tick && cfg.len_en;
	assign len_done = len_step && len_cnt == 8'hFF; // wrap ends play

	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			state <= apu_pkg::CH_OFF;
		end else if (!cfg.dac_en) begin
			state <= apu_pkg::CH_OFF; // dac off wins over trigger
		end else if (trigger) begin
			state <= apu_pkg::CH_PLAY;
		end else if (len_done) begin
			state <= apu_pkg::CH_OFF;
		end
	end

	// period is TIMER_DIV * (2048 - freq) cycles per position
	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			pre_cnt  <= '0;
			freq_cnt <= '0;
			position <= '0;
		end else if (trigger) begin
			pre_cnt  <= '0;
			freq_cnt <= cfg.freq;
			position <= '0;
		end else if (state == apu_pkg::CH_PLAY) begin
			pre_cnt <= (pre_cnt == PRE_LAST) ? '0 : pre_cnt + 1'b1;
			if (step) begin
				if (freq_cnt == FREQ_MAX) begin
					freq_cnt <= cfg.freq; // reload on overflow
					position <= position + 1'b1; // wraps 31 -> 0
				end else begin
					freq_cnt <= freq_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			len_cnt <= '0;
		end else if (trigger || len_reload) begin
			len_cnt <= cfg.len_load;
		end else if (len_step) begin
			len_cnt <= len_cnt + 1'b1; // counts up to the wrap
		end
	end

	assign ch3_active = state == apu_pkg::CH_PLAY;

endmodule

// ==== wave/wave_ram.sv ====
module wave_ram (
	input  logic                      amuk_4mhz,
	input  logic                      arst_n,
	input  logic                      ram_rd,
	input  logic                      ram_wr,
	input  logic [3:0]                ram_addr,
	input  logic [7:0]                wdata,
	input  logic [apu_pkg::POS_W-1:0] position,
	output logic [7:0]                ram_rdata,
	output logic [3:0]                raw_sample
);
	logic [7:0] mem [apu_pkg::WAVE_BYTES];
	logic [7:0] play_byte;
	logic [3:0] play_nib;

	// cpu port
	always_ff @(posedge amuk_4mhz) begin
		if (ram_wr) begin
			mem[ram_addr] <= wdata;
		end
		if (ram_rd) begin
			ram_rdata <= mem[ram_addr];
		end
	end

	// playback port reads two nibbles per byte
	assign play_byte = mem[position[4:1]];
	assign play_nib  = position[0] ? play_byte[3:0] : play_byte[7:4]; // high nibble first

	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			raw_sample <= '0;
		end else begin
			raw_sample <= play_nib;
		end
	end

endmodule

// ==== logic/apu_reg_if.sv ====
module apu_reg_if (
	input  logic              amuk_4mhz,
	input  logic              arst_n,
	input  apu_pkg::cpu_bus_t bus,
	input  logic              ch3_active,
	input  logic [7:0]        ram_rdata,
	output logic [7:0]        rdata,
	output apu_pkg::ch3_cfg_t cfg,
	output logic              trigger,
	output logic              len_reload,
	output logic              ram_rd,
	output logic              ram_wr,
	output logic [3:0]        ram_addr,
	output logic [7:0]        wdata
);
	localparam logic [7:0] RAM_BASE = apu_pkg::WAVE_RAM_BASE;

	apu_pkg::ch3_cfg_t cfg_q;
	logic [7:0]        reg_rdata;
	logic [7:0]        rdata_q;
	logic              ram_sel_q;
	logic              in_win;

	assign in_win   = bus.addr[7:4] == RAM_BASE[7:4];
	assign ram_rd   = bus.rd && in_win && !ch3_active; // ram locked while playing
	assign ram_wr   = bus.wr && in_win && !ch3_active;
	assign ram_addr = bus.addr[3:0];
	assign wdata    = bus.wdata;

	assign trigger    = bus.wr && bus.addr == apu_pkg::NR34 && bus.wdata[7];
	assign len_reload = bus.wr && bus.addr == apu_pkg::NR31;

	// cfg carries the value being written this cycle, so a trigger sees new freq
	always_comb begin
		cfg = cfg_q;
		if (bus.wr) begin
			case (bus.addr)
				apu_pkg::NR30: cfg.dac_en   = bus.wdata[7];
				apu_pkg::NR31: cfg.len_load = bus.wdata;
				apu_pkg::NR32: cfg.vol      = apu_pkg::wave_vol_e'(bus.wdata[6:5]);
				apu_pkg::NR33: cfg.freq[7:0] = bus.wdata;
				apu_pkg::NR34: begin
					cfg.freq[10:8] = bus.wdata[2:0];
					cfg.len_en     = bus.wdata[6];
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		case (bus.addr)
			apu_pkg::NR30: reg_rdata = {cfg_q.dac_en, 7'h7F};
			apu_pkg::NR32: reg_rdata = {1'b1, cfg_q.vol, 5'h1F};
			apu_pkg::NR34: reg_rdata = {1'b1, cfg_q.len_en, 6'h3F};
			default:       reg_rdata = 8'hFF; // write-only, unmapped, locked ram
		endcase
	end

	always_ff @(posedge amuk_4mhz or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q     <= '0;
			rdata_q   <= '0;
			ram_sel_q <= 1'b0;
		end else begin
			cfg_q <= cfg;
			if (bus.rd) begin
				rdata_q   <= reg_rdata;
				ram_sel_q <= ram_rd; // held until the next read
			end
		end
	end

	assign rdata = ram_sel_q ? ram_rdata : rdata_q;

endmodule

// ==== common/apu_pkg.sv ====
package apu_pkg;

	localparam int FREQ_W     = 11; // timer reload width
	localparam int POS_W      = 5;  // 32 nibbles per wave
	localparam int WAVE_BYTES = 16;

	// low address byte of the channel 3 registers
	typedef enum logic [7:0] {
		NR30          = 8'h1A, // dac enable
		NR31          = 8'h1B, // length load
		NR32          = 8'h1C, // volume code
		NR33          = 8'h1D, // freq low byte
		NR34          = 8'h1E, // trigger, length enable, freq high
		WAVE_RAM_BASE = 8'h30  // 8'h30..8'h3F
	} apu_reg_e;

	typedef enum logic [1:0] {
		VOL_MUTE    = 2'd0,
		VOL_FULL    = 2'd1,
		VOL_HALF    = 2'd2, // >> 1
		VOL_QUARTER = 2'd3  // >> 2
	} wave_vol_e;

	typedef enum logic {
		CH_OFF  = 1'b0,
		CH_PLAY = 1'b1
	} ch_state_e;

	typedef struct packed {
		logic       rd;
		logic       wr;
		logic [7:0] addr;
		logic [7:0] wdata;
	} cpu_bus_t;

	typedef struct packed {
		logic              dac_en;   // NR30[7]
		logic [7:0]        len_load; // NR31
		wave_vol_e         vol;      // NR32[6:5]
		logic [FREQ_W-1:0] freq;     // {NR34[2:0], NR33}
		logic              len_en;   // NR34[6]
	} ch3_cfg_t;

endpackage
